//--- eyeriss_defs.svh
`ifndef EYERISS_DEFS_SVH
`define EYERISS_DEFS_SVH

// Default array size
`define ARR_HEIGHT 4
`define ARR_WIDTH 4

// Datapath widths
`define DATA_W 8    // Feature map and weight, sign bit included
`define ACC_W 24    // Accumulator and output register

`endif

//--- hdl/pe_types_pkg.sv
`include "eyeriss_defs.svh"

package pe_types_pkg;

    // Feature map value as it arrives at the border PE
    typedef logic signed [`DATA_W-1:0] ifm_t;

    // Magnitude part of a sign-magnitude input or weight
    typedef logic [`DATA_W-2:0] mag_t;

    // Partial sum, wraps on overflow
    typedef logic signed [`ACC_W-1:0] acc_t;

endpackage

//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_LOAD_W  = 3'd1,    // Shift weights down one row
        OP_CLR_W   = 3'd2,
        OP_CLR_ACC = 3'd3,
        OP_MAC     = 3'd4,
        OP_DONE    = 3'd5,    // Snapshot accumulators
        OP_READ    = 3'd6,
        OP_CLR_OUT = 3'd7
    } op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_DRAIN = 2'd1,      // Waiting for mac_done to reach the last column
        ST_READ  = 2'd2
    } seq_state_e;

endpackage

//--- hdl/pe_inner.sv
`timescale 1ns/1ns

module pe_inner (
    input  logic               clk,
    input  logic               rst_n_i,

    input  logic               en_i_i,
    input  logic               clr_i_i,
    input  logic               mac_done_i,
    input  logic               ifm_sign_i,
    input  pe_types_pkg::mag_t ifm_abs_i,
    output logic               en_i_o,
    output logic               clr_i_o,
    output logic               mac_done_o,
    output logic               ifm_sign_o,
    output pe_types_pkg::mag_t ifm_abs_o,

    input  logic               en_w_i,
    input  logic               clr_w_i,
    input  logic               wght_sign_i,
    input  pe_types_pkg::mag_t wght_abs_i,
    output logic               en_w_o,
    output logic               clr_w_o,
    output logic               wght_sign_o,
    output pe_types_pkg::mag_t wght_abs_o,

    input  logic               en_o_i,
    input  logic               clr_o_i,
    input  pe_types_pkg::acc_t ofm_i,
    output logic               en_o_o,
    output logic               clr_o_o,
    output pe_types_pkg::acc_t ofm_o
);
    import pe_types_pkg::*;

    logic [2*$bits(mag_t)-1:0] prod_abs;
    acc_t                      prod;
    acc_t                      acc_q;

    assign prod_abs = ifm_abs_i * wght_abs_o;
    assign prod     = (ifm_sign_i ^ wght_sign_o) ? -acc_t'(prod_abs) : acc_t'(prod_abs);

    // Column strobes reach every row in the same cycle
    assign en_w_o  = en_w_i;
    assign clr_w_o = clr_w_i;
    assign en_o_o  = en_o_i;
    assign clr_o_o = clr_o_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_i_o     <= 1'b0;
            clr_i_o    <= 1'b0;
            mac_done_o <= 1'b0;
            ifm_sign_o <= 1'b0;
            ifm_abs_o  <= '0;
        end else begin
            en_i_o     <= en_i_i;        // One PE per clock to the right
            clr_i_o    <= clr_i_i;
            mac_done_o <= mac_done_i;
            ifm_sign_o <= ifm_sign_i;
            ifm_abs_o  <= ifm_abs_i;
        end
    end

    // Stored weight doubles as the next row's weight input
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wght_sign_o <= 1'b0;
            wght_abs_o  <= '0;
        end else if (clr_w_i) begin
            wght_sign_o <= 1'b0;
            wght_abs_o  <= '0;
        end else if (en_w_i) begin
            wght_sign_o <= wght_sign_i;
            wght_abs_o  <= wght_abs_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else if (en_i_i) begin
            acc_q <= clr_i_i ? prod : acc_q + prod;    // Clear and MAC together restart the sum
        end else if (clr_i_i) begin
            acc_q <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ofm_o <= '0;
        end else if (mac_done_i) begin
            ofm_o <= acc_q;
        end else if (en_o_i) begin
            ofm_o <= ofm_i;              // Shift up from the row below
        end else if (clr_o_i) begin
            ofm_o <= '0;
        end
    end

endmodule

//--- hdl/pe_border.sv
`timescale 1ns/1ns

module pe_border (
    input  logic               clk,
    input  logic               rst_n_i,

    input  logic               en_i_i,
    input  logic               clr_i_i,
    input  logic               mac_done_i,
    input  pe_types_pkg::ifm_t ifm_i,
    output logic               en_i_o,
    output logic               clr_i_o,
    output logic               mac_done_o,
    output logic               ifm_sign_o,
    output pe_types_pkg::mag_t ifm_abs_o,

    input  logic               en_w_i,
    input  logic               clr_w_i,
    input  logic               wght_sign_i,
    input  pe_types_pkg::mag_t wght_abs_i,
    output logic               en_w_o,
    output logic               clr_w_o,
    output logic               wght_sign_o,
    output pe_types_pkg::mag_t wght_abs_o,

    input  logic               en_o_i,
    input  logic               clr_o_i,
    input  pe_types_pkg::acc_t ofm_i,
    output logic               en_o_o,
    output logic               clr_o_o,
    output pe_types_pkg::acc_t ofm_o
);
    import pe_types_pkg::*;

    logic ifm_sign;
    ifm_t ifm_neg;
    mag_t ifm_abs;

    assign ifm_sign = ifm_i[$bits(ifm_t)-1];
    assign ifm_neg  = -ifm_i;

    // -128 negates to itself, so it saturates to 127
    assign ifm_abs = !ifm_sign                 ? ifm_i[$bits(mag_t)-1:0] :
                     ifm_neg[$bits(ifm_t)-1]   ? '1 :
                                                 ifm_neg[$bits(mag_t)-1:0];

    pe_inner u_pe_inner (
        .clk(clk), .rst_n_i(rst_n_i),
        .en_i_i(en_i_i), .clr_i_i(clr_i_i), .mac_done_i(mac_done_i),
        .ifm_sign_i(ifm_sign), .ifm_abs_i(ifm_abs),
        .en_i_o(en_i_o), .clr_i_o(clr_i_o), .mac_done_o(mac_done_o),
        .ifm_sign_o(ifm_sign_o), .ifm_abs_o(ifm_abs_o),
        .en_w_i(en_w_i), .clr_w_i(clr_w_i),
        .wght_sign_i(wght_sign_i), .wght_abs_i(wght_abs_i),
        .en_w_o(en_w_o), .clr_w_o(clr_w_o),
        .wght_sign_o(wght_sign_o), .wght_abs_o(wght_abs_o),
        .en_o_i(en_o_i), .clr_o_i(clr_o_i), .ofm_i(ofm_i),
        .en_o_o(en_o_o), .clr_o_o(clr_o_o), .ofm_o(ofm_o)
    );

endmodule

//--- hdl/array_eyeriss.sv
`timescale 1ns/1ns
`include "eyeriss_defs.svh"

module array_eyeriss #(
    parameter int HEIGHT = `ARR_HEIGHT,
    parameter int WIDTH  = `ARR_WIDTH
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               en_i_i,
    input  logic               clr_i_i,
    input  logic               mac_done_i,
    input  pe_types_pkg::ifm_t ifm_i [HEIGHT-1:0],
    input  logic               en_w_i,
    input  logic               clr_w_i,
    input  logic               en_o_i,
    input  logic               clr_o_i,
    input  logic               wght_sign_i [WIDTH-1:0],
    input  pe_types_pkg::mag_t wght_abs_i [WIDTH-1:0],
    output pe_types_pkg::acc_t ofm_o [WIDTH-1:0]
);
    import pe_types_pkg::*;

    // Row chains, index is the column the signal enters
    logic en_i_x     [HEIGHT-1:0][WIDTH:0];
    logic clr_i_x    [HEIGHT-1:0][WIDTH:0];
    logic mac_done_x [HEIGHT-1:0][WIDTH:0];
    logic ifm_sign_x [HEIGHT-1:0][WIDTH:1];
    mag_t ifm_abs_x  [HEIGHT-1:0][WIDTH:1];

    // Column chains, index is the row the signal enters
    logic en_w_x      [WIDTH-1:0][HEIGHT:0];
    logic clr_w_x     [WIDTH-1:0][HEIGHT:0];
    logic wght_sign_x [WIDTH-1:0][HEIGHT:0];
    mag_t wght_abs_x  [WIDTH-1:0][HEIGHT:0];
    logic en_o_x      [WIDTH-1:0][HEIGHT:0];
    logic clr_o_x     [WIDTH-1:0][HEIGHT:0];
    acc_t ofm_x       [WIDTH-1:0][HEIGHT:0];

    for (genvar w = 0; w < WIDTH; w++) begin : g_col
        assign en_w_x[w][0]      = en_w_i;
        assign clr_w_x[w][0]     = clr_w_i;
        assign wght_sign_x[w][0] = wght_sign_i[w];
        assign wght_abs_x[w][0]  = wght_abs_i[w];
        assign en_o_x[w][HEIGHT]  = en_o_i;        // Readout strobes enter at the bottom
        assign clr_o_x[w][HEIGHT] = clr_o_i;
        assign ofm_x[w][HEIGHT]   = '0;
        assign ofm_o[w]           = ofm_x[w][0];
    end

    for (genvar h = 0; h < HEIGHT; h++) begin : g_row
        assign en_i_x[h][0]     = en_i_i;
        assign clr_i_x[h][0]    = clr_i_i;
        assign mac_done_x[h][0] = mac_done_i;

        pe_border u_pe_border (
            .clk(clk), .rst_n_i(rst_n_i),
            .en_i_i(en_i_x[h][0]), .clr_i_i(clr_i_x[h][0]), .mac_done_i(mac_done_x[h][0]),
            .ifm_i(ifm_i[h]),
            .en_i_o(en_i_x[h][1]), .clr_i_o(clr_i_x[h][1]), .mac_done_o(mac_done_x[h][1]),
            .ifm_sign_o(ifm_sign_x[h][1]), .ifm_abs_o(ifm_abs_x[h][1]),
            .en_w_i(en_w_x[0][h]), .clr_w_i(clr_w_x[0][h]),
            .wght_sign_i(wght_sign_x[0][h]), .wght_abs_i(wght_abs_x[0][h]),
            .en_w_o(en_w_x[0][h+1]), .clr_w_o(clr_w_x[0][h+1]),
            .wght_sign_o(wght_sign_x[0][h+1]), .wght_abs_o(wght_abs_x[0][h+1]),
            .en_o_i(en_o_x[0][h+1]), .clr_o_i(clr_o_x[0][h+1]), .ofm_i(ofm_x[0][h+1]),
            .en_o_o(en_o_x[0][h]), .clr_o_o(clr_o_x[0][h]), .ofm_o(ofm_x[0][h])
        );

        for (genvar w = 1; w < WIDTH; w++) begin : g_pe
            pe_inner u_pe_inner (
                .clk(clk), .rst_n_i(rst_n_i),
                .en_i_i(en_i_x[h][w]), .clr_i_i(clr_i_x[h][w]),
                .mac_done_i(mac_done_x[h][w]),
                .ifm_sign_i(ifm_sign_x[h][w]), .ifm_abs_i(ifm_abs_x[h][w]),
                .en_i_o(en_i_x[h][w+1]), .clr_i_o(clr_i_x[h][w+1]),
                .mac_done_o(mac_done_x[h][w+1]),
                .ifm_sign_o(ifm_sign_x[h][w+1]), .ifm_abs_o(ifm_abs_x[h][w+1]),
                .en_w_i(en_w_x[w][h]), .clr_w_i(clr_w_x[w][h]),
                .wght_sign_i(wght_sign_x[w][h]), .wght_abs_i(wght_abs_x[w][h]),
                .en_w_o(en_w_x[w][h+1]), .clr_w_o(clr_w_x[w][h+1]),
                .wght_sign_o(wght_sign_x[w][h+1]), .wght_abs_o(wght_abs_x[w][h+1]),
                .en_o_i(en_o_x[w][h+1]), .clr_o_i(clr_o_x[w][h+1]), .ofm_i(ofm_x[w][h+1]),
                .en_o_o(en_o_x[w][h]), .clr_o_o(clr_o_x[w][h]), .ofm_o(ofm_x[w][h])
            );
        end
    end

endmodule

//--- hdl/eyeriss_seq.sv
`timescale 1ns/1ns
`include "eyeriss_defs.svh"

module eyeriss_seq #(
    parameter int HEIGHT = `ARR_HEIGHT,
    parameter int WIDTH  = `ARR_WIDTH
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               cmd_valid_i,
    input  ctrl_pkg::op_e      cmd_op_i,
    input  pe_types_pkg::ifm_t ifm_i [HEIGHT-1:0],
    input  logic               wght_sign_i [WIDTH-1:0],
    input  pe_types_pkg::mag_t wght_abs_i [WIDTH-1:0],
    output logic               en_i_o,
    output logic               clr_i_o,
    output logic               mac_done_o,
    output pe_types_pkg::ifm_t ifm_o [HEIGHT-1:0],
    output logic               en_w_o,
    output logic               clr_w_o,
    output logic               en_o_o,
    output logic               clr_o_o,
    output logic               wght_sign_o [WIDTH-1:0],
    output pe_types_pkg::mag_t wght_abs_o [WIDTH-1:0],
    output logic               busy_o,
    output logic               ofm_valid_o
);
    import ctrl_pkg::*;

    localparam int CNT_MAX = (WIDTH > HEIGHT) ? WIDTH : HEIGHT;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    seq_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             accept;

    assign accept      = cmd_valid_i && (state_q == ST_IDLE);
    assign busy_o      = (state_q != ST_IDLE);
    assign ofm_valid_o = (state_q == ST_READ);
    assign en_o_o      = (state_q == ST_READ);    // Shift up after every beat

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_i_o     <= 1'b0;
            clr_i_o    <= 1'b0;
            mac_done_o <= 1'b0;
            en_w_o     <= 1'b0;
            clr_w_o    <= 1'b0;
            clr_o_o    <= 1'b0;
        end else begin
            en_i_o     <= accept && (cmd_op_i == OP_MAC);
            clr_i_o    <= accept && (cmd_op_i == OP_CLR_ACC);
            mac_done_o <= accept && (cmd_op_i == OP_DONE);
            en_w_o     <= accept && (cmd_op_i == OP_LOAD_W);
            clr_w_o    <= accept && (cmd_op_i == OP_CLR_W);
            clr_o_o    <= accept && (cmd_op_i == OP_CLR_OUT);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ifm_o       <= '{default: '0};
            wght_sign_o <= '{default: 1'b0};
            wght_abs_o  <= '{default: '0};
        end else if (accept) begin
            ifm_o       <= ifm_i;
            wght_sign_o <= wght_sign_i;
            wght_abs_o  <= wght_abs_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    cnt_q <= '0;
                    if (accept && (cmd_op_i == OP_DONE)) begin
                        state_q <= ST_DRAIN;
                    end else if (accept && (cmd_op_i == OP_READ)) begin
                        state_q <= ST_READ;
                    end
                end
                ST_DRAIN: begin
                    if (cnt_q == CNT_W'(WIDTH)) begin    // Last column has copied
                        state_q <= ST_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_READ: begin
                    if (cnt_q == CNT_W'(HEIGHT - 1)) begin
                        state_q <= ST_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/eyeriss_top.sv
`timescale 1ns/1ns
`include "eyeriss_defs.svh"

module eyeriss_top #(
    parameter int HEIGHT = `ARR_HEIGHT,
    parameter int WIDTH  = `ARR_WIDTH
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               cmd_valid_i,
    input  ctrl_pkg::op_e      cmd_op_i,
    input  pe_types_pkg::ifm_t ifm_i [HEIGHT-1:0],
    input  logic               wght_sign_i [WIDTH-1:0],
    input  pe_types_pkg::mag_t wght_abs_i [WIDTH-1:0],
    output logic               busy_o,
    output logic               ofm_valid_o,
    output pe_types_pkg::acc_t ofm_o [WIDTH-1:0]
);
    import pe_types_pkg::*;

    logic en_i;
    logic clr_i;
    logic mac_done;
    logic en_w;
    logic clr_w;
    logic en_o;
    logic clr_o;
    ifm_t ifm       [HEIGHT-1:0];
    logic wght_sign [WIDTH-1:0];
    mag_t wght_abs  [WIDTH-1:0];

    eyeriss_seq #(
        .HEIGHT(HEIGHT),
        .WIDTH(WIDTH)
    ) u_eyeriss_seq (
        .clk(clk), .rst_n_i(rst_n_i),
        .cmd_valid_i(cmd_valid_i), .cmd_op_i(cmd_op_i),
        .ifm_i(ifm_i), .wght_sign_i(wght_sign_i), .wght_abs_i(wght_abs_i),
        .en_i_o(en_i), .clr_i_o(clr_i), .mac_done_o(mac_done), .ifm_o(ifm),
        .en_w_o(en_w), .clr_w_o(clr_w), .en_o_o(en_o), .clr_o_o(clr_o),
        .wght_sign_o(wght_sign), .wght_abs_o(wght_abs),
        .busy_o(busy_o), .ofm_valid_o(ofm_valid_o)
    );

    array_eyeriss #(
        .HEIGHT(HEIGHT),
        .WIDTH(WIDTH)
    ) u_array_eyeriss (
        .clk(clk), .rst_n_i(rst_n_i),
        .en_i_i(en_i), .clr_i_i(clr_i), .mac_done_i(mac_done), .ifm_i(ifm),
        .en_w_i(en_w), .clr_w_i(clr_w), .en_o_i(en_o), .clr_o_i(clr_o),
        .wght_sign_i(wght_sign), .wght_abs_i(wght_abs),
        .ofm_o(ofm_o)
    );

endmodule

//--- bench/eyeriss_checker.sv
`timescale 1ns/1ns
`include "eyeriss_defs.svh"

module eyeriss_checker (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               cmd_valid_i,
    input  ctrl_pkg::op_e      cmd_op_i,
    input  pe_types_pkg::ifm_t ifm_i [`ARR_HEIGHT-1:0],
    input  logic               wght_sign_i [`ARR_WIDTH-1:0],
    input  pe_types_pkg::mag_t wght_abs_i [`ARR_WIDTH-1:0],
    input  logic               busy_i,
    input  logic               ofm_valid_i,
    input  pe_types_pkg::acc_t ofm_i [`ARR_WIDTH-1:0],
    output int                 val_errs_o,
    output int                 proto_errs_o
);
    import ctrl_pkg::*;
    import pe_types_pkg::*;

    localparam int H        = `ARR_HEIGHT;
    localparam int W        = `ARR_WIDTH;
    localparam int MAG_MAX  = (1 << (`DATA_W - 1)) - 1;
    localparam int BUSY_MAX = H + W + 2;    // Longer than any drain or readout

    int   wgt  [H][W];    // Signed weight per PE
    acc_t acc  [H][W];
    acc_t outr [H][W];
    int   pending;        // Beats still owed by the last READ
    int   beat;
    int   busy_run;
    int   busy_left;      // Cycles of busy_o still owed by the last DONE or READ
    logic started;

    // Most negative input counts as -MAG_MAX
    function automatic int saturated_value(ifm_t v);
        return (int'(v) < -MAG_MAX) ? -MAG_MAX : int'(v);
    endfunction

    task automatic apply_command();
        if (pending != 0) begin
            proto_errs_o++;
            $display("command accepted while %0d readout beats were still missing", pending);
        end
        for (int h = H - 1; h >= 0; h--) begin    // Bottom first so LOAD_W shifts down
            for (int w = 0; w < W; w++) begin
                case (cmd_op_i)
                    OP_LOAD_W: begin
                        if (h == 0) begin
                            wgt[h][w] = wght_sign_i[w] ? -int'(wght_abs_i[w])
                                                       : int'(wght_abs_i[w]);
                        end else begin
                            wgt[h][w] = wgt[h-1][w];
                        end
                    end
                    OP_CLR_W:   wgt[h][w] = 0;
                    OP_CLR_ACC: acc[h][w] = '0;
                    OP_MAC:     acc[h][w] = acc[h][w] +
                                            acc_t'(saturated_value(ifm_i[h]) * wgt[h][w]);
                    OP_DONE:    outr[h][w] = acc[h][w];
                    OP_CLR_OUT: outr[h][w] = '0;
                    default: ;
                endcase
            end
        end
        if (cmd_op_i == OP_READ) begin
            pending   = H;
            busy_left = H;
        end else if (cmd_op_i == OP_DONE) begin
            busy_left = W + 1;    // Drain until the last column has copied
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n_i) begin
            for (int h = 0; h < H; h++) begin
                for (int w = 0; w < W; w++) begin
                    wgt[h][w]  = 0;
                    acc[h][w]  = '0;
                    outr[h][w] = '0;
                end
            end
            pending   = 0;
            beat      = 0;
            busy_run  = 0;
            busy_left = 0;
            started   = 1'b0;
        end else begin
            if (!started && (busy_i || ofm_valid_i)) begin
                proto_errs_o++;
                $display("busy_o or ofm_valid_o high after reset before any command");
            end
            if (busy_i !== (busy_left != 0)) begin
                val_errs_o++;
                $display("error: busy_o got %h expected %h", busy_i, busy_left != 0);
            end
            if (busy_left != 0) begin
                busy_left--;    // Commands offered now are dropped
            end else if (cmd_valid_i) begin
                started = 1'b1;
                apply_command();
            end
            if (ofm_valid_i) begin
                if (pending == 0) begin
                    proto_errs_o++;
                    $display("ofm_valid_o high with no read outstanding");
                end else begin
                    pending--;
                end
                for (int w = 0; w < W; w++) begin
                    if (ofm_i[w] !== outr[0][w]) begin
                        val_errs_o++;
                        $display("error: ofm_o[%0d] beat %0d got %h expected %h",
                                 w, beat, ofm_i[w], outr[0][w]);
                    end
                    for (int h = 0; h < H - 1; h++) begin
                        outr[h][w] = outr[h+1][w];    // Chain moves up, zero enters below
                    end
                    outr[H-1][w] = '0;
                end
                beat++;
            end else if (beat != 0) begin
                if (beat != H) begin
                    proto_errs_o++;
                    $display("read gave %0d valid beats instead of %0d", beat, H);
                end
                beat = 0;
            end
            busy_run = busy_i ? busy_run + 1 : 0;
            if (busy_run == BUSY_MAX) begin
                proto_errs_o++;
                $display("busy_o stuck high for %0d cycles", BUSY_MAX);
            end
        end
    end

endmodule

//--- bench/tb_eyeriss.sv
`timescale 1ns/1ns
`include "eyeriss_defs.svh"

module tb_eyeriss;
    import ctrl_pkg::*;
    import pe_types_pkg::*;

    localparam int H         = `ARR_HEIGHT;
    localparam int W         = `ARR_WIDTH;
    localparam int FIX_LEN   = 50;
    localparam int WRAP_MACS = 530;    // Full-scale products summed past 2**23
    localparam int TBL_LEN   = FIX_LEN + H + 1 + WRAP_MACS + 2;
    localparam int TIMEOUT   = TBL_LEN * (`ARR_HEIGHT + `ARR_WIDTH + 3) + 20;
    localparam int BUSY_IDX  = 21;    // Offered during a drain, must be dropped

    logic clk = 1'b0;
    logic rst_n_i;
    logic cmd_valid_i;
    op_e  cmd_op_i;
    ifm_t ifm_i [H-1:0];
    logic wght_sign_i [W-1:0];
    mag_t wght_abs_i [W-1:0];
    logic busy_o;
    logic ofm_valid_o;
    acc_t ofm_o [W-1:0];
    int   val_errs;
    int   proto_errs;
    int   cycles = 0;
    int   seed = 59;

    op_e  fixed_op [FIX_LEN];
    op_e  tbl_op  [TBL_LEN];
    ifm_t tbl_ifm [TBL_LEN][H];
    logic tbl_ws  [TBL_LEN][W];
    mag_t tbl_wa  [TBL_LEN][W];
    ifm_t edge_val [4] = '{8'h80, 8'h7f, 8'h00, 8'hff};    // -128, 127, 0, -1

    eyeriss_top #(
        .HEIGHT(H),
        .WIDTH(W)
    ) eyeriss_top_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .cmd_valid_i(cmd_valid_i), .cmd_op_i(cmd_op_i),
        .ifm_i(ifm_i), .wght_sign_i(wght_sign_i), .wght_abs_i(wght_abs_i),
        .busy_o(busy_o), .ofm_valid_o(ofm_valid_o), .ofm_o(ofm_o)
    );

    eyeriss_checker eyeriss_checker_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .cmd_valid_i(cmd_valid_i), .cmd_op_i(cmd_op_i),
        .ifm_i(ifm_i), .wght_sign_i(wght_sign_i), .wght_abs_i(wght_abs_i),
        .busy_i(busy_o), .ofm_valid_i(ofm_valid_o), .ofm_i(ofm_o),
        .val_errs_o(val_errs), .proto_errs_o(proto_errs)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_op_i    = OP_NOP;
        for (int h = 0; h < H; h++) ifm_i[h] = '0;
        for (int w = 0; w < W; w++) begin
            wght_sign_i[w] = 1'b0;
            wght_abs_i[w]  = '0;
        end

        fixed_op = '{OP_LOAD_W, OP_LOAD_W, OP_LOAD_W, OP_LOAD_W, OP_CLR_ACC, OP_MAC,
                     OP_DONE, OP_READ, OP_CLR_W, OP_CLR_ACC, OP_MAC, OP_DONE, OP_READ,
                     OP_LOAD_W, OP_LOAD_W, OP_LOAD_W, OP_LOAD_W, OP_CLR_ACC, OP_MAC,
                     OP_MAC, OP_DONE, OP_CLR_OUT, OP_READ,
                     OP_LOAD_W, OP_LOAD_W, OP_LOAD_W, OP_LOAD_W, OP_CLR_ACC,
                     OP_MAC, OP_MAC, OP_MAC, OP_MAC, OP_MAC, OP_MAC, OP_MAC, OP_MAC,
                     OP_DONE, OP_READ, OP_CLR_ACC, OP_MAC, OP_MAC, OP_MAC, OP_DONE,
                     OP_MAC, OP_MAC, OP_READ, OP_DONE, OP_CLR_OUT, OP_READ, OP_NOP};
        for (int i = 0; i < TBL_LEN; i++) begin
            if (i < FIX_LEN) begin
                tbl_op[i] = fixed_op[i];
            end else begin
                tbl_op[i] = OP_MAC;
            end
            for (int h = 0; h < H; h++) tbl_ifm[i][h] = ifm_t'($random(seed));
            for (int w = 0; w < W; w++) begin
                tbl_ws[i][w] = 1'($random(seed));
                tbl_wa[i][w] = mag_t'($random(seed));
                if (i >= 13 && i <= 16) begin    // Edge weights, both signs
                    tbl_ws[i][w] = 1'((i + w) % 2);
                    if (w == 0) tbl_wa[i][w] = '1;
                    else if (w == 1) tbl_wa[i][w] = '0;
                end
                if (i >= FIX_LEN) tbl_wa[i][w] = '1;
            end
            if (i >= FIX_LEN) begin    // Long run of -127 inputs wraps every sum
                for (int h = 0; h < H; h++) tbl_ifm[i][h] = ifm_t'(8'h80);
            end
        end
        for (int h = 0; h < H; h++) begin
            tbl_ifm[5][h]  = ifm_t'(1);    // Reads back the weights
            tbl_ifm[18][h] = edge_val[h % 4];
            tbl_ifm[19][h] = edge_val[(h + 1) % 4];
        end
        for (int k = 0; k < H; k++) tbl_op[FIX_LEN + k] = OP_LOAD_W;
        tbl_op[FIX_LEN + H] = OP_CLR_ACC;
        tbl_op[TBL_LEN - 2] = OP_DONE;
        tbl_op[TBL_LEN - 1] = OP_READ;

        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < TBL_LEN; i++) begin
            @(negedge clk);
            while (busy_o && i != BUSY_IDX) @(negedge clk);
            @(posedge clk);
            cmd_valid_i <= 1'b1;
            cmd_op_i    <= tbl_op[i];
            for (int h = 0; h < H; h++) ifm_i[h] <= tbl_ifm[i][h];
            for (int w = 0; w < W; w++) begin
                wght_sign_i[w] <= tbl_ws[i][w];
                wght_abs_i[w]  <= tbl_wa[i][w];
            end
            @(posedge clk);
            cmd_valid_i <= 1'b0;
            cmd_op_i    <= OP_NOP;
        end
        @(negedge clk);
        while (busy_o) @(negedge clk);
        repeat (2) @(posedge clk);

        $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- eyeriss.f
+incdir+.
hdl/pe_types_pkg.sv
hdl/ctrl_pkg.sv
hdl/pe_inner.sv
hdl/pe_border.sv
hdl/array_eyeriss.sv
hdl/eyeriss_seq.sv
hdl/eyeriss_top.sv
bench/eyeriss_checker.sv
bench/tb_eyeriss.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the systolic array testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_eyeriss -f eyeriss.f -o sim_eyeriss
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_eyeriss > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
